// ==== src/AdcPkg.sv ====
package AdcPkg;

    ////////////////////////////////////////////////////////////////////////////
    // ADC and accumulation
    ////////////////////////////////////////////////////////////////////////////

    // AD9220 class converter, 12 bit with 3 clock latency
    localparam int AdcWidth      = 12;
    localparam int AdcPipeDelay  = 3;
    // Clk cycles per ADC clock period
    localparam int AdcClkDiv     = 10;
    localparam int HalfPeriod    = AdcClkDiv / 2;
    localparam int PhaseWidth    = $clog2(HalfPeriod);
    // Sample strobe sits mid way through the low phase
    localparam int CaptureTick   = HalfPeriod / 2;
    // Fill counter has to reach AdcPipeDelay+1
    localparam int FillWidth     = $clog2(AdcPipeDelay + 2);

    // Conversions per Hold and the sum that holds them
    localparam int SampleCount   = 32;
    localparam int CountWidth    = $clog2(SampleCount);
    localparam int SumWidth      = 17;
    localparam int ResultWidth   = 16;
    // Over-range flag rides in the top bit
    localparam int FifoWordWidth = ResultWidth + 1;

    // Result queue
    localparam int FifoDepth      = 8;
    localparam int PtrWidth       = $clog2(FifoDepth);
    localparam int FifoCountWidth = PtrWidth + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////

    localparam int AddrWidth    = 2;
    localparam int CfgDataWidth = 8;
    localparam int DelayWidth   = 4;
    localparam int DropWidth    = 8;

    localparam logic [AddrWidth-1:0] CtrlAddr  = 2'd0;
    localparam logic [AddrWidth-1:0] DelayAddr = 2'd1;
    // Read only, a write clears it
    localparam logic [AddrWidth-1:0] DropAddr  = 2'd2;

    // Controller states
    typedef enum logic [2:0] {
        Idle,
        WaitDelay,
        Collect,
        Halve,
        Emit
    } AcqState;

endpackage

// ==== src/AdcSampler.sv ====
`timescale 1ns/1ps

module AdcSampler
    import AdcPkg::*;
(
    input  logic                Clk,
    input  logic                reset_n,
    input  logic                SamplerRun,
    input  logic [AdcWidth-1:0] AdcData,
    input  logic                AdcOtr,
    output logic                AdcClk,
    output logic                SampleValid,
    output logic [AdcWidth-1:0] Sample,
    output logic                SampleOtr
);

    // Position inside the current half period
    logic [PhaseWidth-1:0] phaseCount;
    // Rising edges seen since the burst began, saturating
    logic [FillWidth-1:0]  fillCount;
    logic                  halfDone;
    logic                  risingNext;
    logic                  fillDone;
    logic                  captureNow;

    assign halfDone   = (phaseCount == PhaseWidth'(HalfPeriod - 1));
    // Toggle out of the low phase is a rising edge
    assign risingNext = halfDone && !AdcClk;
    // Data after this many edges is a real conversion
    assign fillDone   = (fillCount == FillWidth'(AdcPipeDelay + 1));
    // Middle of the low phase, ADC outputs settled long ago
    assign captureNow = SamplerRun && !AdcClk && fillDone &&
                        (phaseCount == PhaseWidth'(CaptureTick));

    ////////////////////////////////////////////////////////////////////////////
    // ADC clock and pipeline fill
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            phaseCount <= '0;
            AdcClk     <= 1'b0;
            fillCount  <= '0;
        end else if (!SamplerRun) begin
            // Parked low, next burst refills the pipeline
            phaseCount <= '0;
            AdcClk     <= 1'b0;
            fillCount  <= '0;
        end else begin
            if (halfDone) begin
                phaseCount <= '0;
                AdcClk     <= !AdcClk;
            end else begin
                phaseCount <= phaseCount + 1'b1;
            end

            // Count edges only until the pipeline is primed
            if (risingNext && !fillDone) begin
                fillCount <= fillCount + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Conversion capture
    ////////////////////////////////////////////////////////////////////////////

    // One pulse per ADC period
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            SampleValid <= 1'b0;
        end else begin
            SampleValid <= captureNow;
        end
    end

    // Data bus and over-range bit taken together
    always_ff @(posedge Clk) begin
        if (captureNow) begin
            Sample    <= AdcData;
            SampleOtr <= AdcOtr;
        end
    end

endmodule

// ==== src/AdcControl.sv ====
`timescale 1ns/1ps

module AdcControl
    import AdcPkg::*;
(
    input  logic                   Clk,
    input  logic                   reset_n,
    input  logic                   Hold,
    input  logic                   AcqEnable,
    input  logic [DelayWidth-1:0]  StartDelay,
    input  logic                   SampleValid,
    input  logic [AdcWidth-1:0]    Sample,
    input  logic                   SampleOtr,
    output logic                   SamplerRun,
    output logic                   ResultValid,
    output logic [ResultWidth-1:0] Result,
    output logic                   ResultOtr
);

    AcqState               state;

    // Hold synchronizer and edge register
    logic                  holdSync1;
    logic                  holdSync2;
    logic                  holdLast;
    logic                  holdRise;

    logic [DelayWidth-1:0] delayCount;
    logic [CountWidth-1:0] sampleCount;
    logic                  lastSample;
    logic                  burstStart;

    // Running sum and sticky over-range
    logic [SumWidth-1:0]   accum;
    logic                  otrSticky;

    ////////////////////////////////////////////////////////////////////////////
    // Hold edge detection
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            holdSync1 <= 1'b0;
            holdSync2 <= 1'b0;
            holdLast  <= 1'b0;
        end else begin
            holdSync1 <= Hold;
            holdSync2 <= holdSync1;
            holdLast  <= holdSync2;
        end
    end

    assign holdRise   = holdSync2 && !holdLast;
    // Edges outside Idle or while disabled are simply lost
    assign burstStart = (state == Idle) && holdRise && AcqEnable;
    assign lastSample = SampleValid && (sampleCount == CountWidth'(SampleCount - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Acquisition FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= Idle;
            delayCount  <= '0;
            sampleCount <= '0;
        end else begin
            case (state)
                Idle: begin
                    delayCount  <= '0;
                    sampleCount <= '0;
                    if (burstStart) begin
                        state <= WaitDelay;
                    end
                end
                // StartDelay+1 cycles here
                WaitDelay: begin
                    if (delayCount == StartDelay) begin
                        state <= Collect;
                    end else begin
                        delayCount <= delayCount + 1'b1;
                    end
                end
                Collect: begin
                    if (SampleValid) begin
                        sampleCount <= sampleCount + 1'b1;
                    end
                    if (lastSample) begin
                        state <= Halve;
                    end
                end
                Halve: begin
                    state <= Emit;
                end
                Emit: begin
                    state <= Idle;
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Accumulator
    ////////////////////////////////////////////////////////////////////////////

    // 32 x 4095 still fits in 17 bits
    always_ff @(posedge Clk) begin
        if (burstStart) begin
            accum     <= '0;
            otrSticky <= 1'b0;
        end else if ((state == Collect) && SampleValid) begin
            accum     <= accum + SumWidth'(Sample);
            otrSticky <= otrSticky | SampleOtr;
        end else if (state == Halve) begin
            accum <= accum >> 1;
        end
    end

    // Sampler only clocks the ADC during the burst
    assign SamplerRun  = (state == Collect);
    // Single cycle strobe, Emit never repeats
    assign ResultValid = (state == Emit);
    assign Result      = accum[ResultWidth-1:0];
    assign ResultOtr   = otrSticky;

endmodule

// ==== src/AcqConfig.sv ====
`timescale 1ns/1ps

module AcqConfig
    import AdcPkg::*;
(
    input  logic                    Clk,
    input  logic                    reset_n,
    input  logic                    CfgWrite,
    input  logic [AddrWidth-1:0]    CfgAddr,
    input  logic [CfgDataWidth-1:0] CfgWriteData,
    output logic [CfgDataWidth-1:0] CfgReadData,
    input  logic                    Dropped,
    output logic                    AcqEnable,
    output logic [DelayWidth-1:0]   StartDelay
);

    // Lost results, stops at all ones
    logic [DropWidth-1:0] dropCount;
    logic                 dropFull;

    assign dropFull = &dropCount;

    ////////////////////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            AcqEnable  <= 1'b0;
            StartDelay <= '0;
        end else if (CfgWrite) begin
            if (CfgAddr == CtrlAddr) begin
                AcqEnable <= CfgWriteData[0];
            end
            if (CfgAddr == DelayAddr) begin
                StartDelay <= CfgWriteData[DelayWidth-1:0];
            end
        end
    end

    // Clear by write wins over a drop in the same cycle
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            dropCount <= '0;
        end else if (CfgWrite && (CfgAddr == DropAddr)) begin
            dropCount <= '0;
        end else if (Dropped && !dropFull) begin
            dropCount <= dropCount + 1'b1;
        end
    end

    // Readback, zero extended, unmapped reads as zero
    always_comb begin
        case (CfgAddr)
            CtrlAddr:  CfgReadData = CfgDataWidth'(AcqEnable);
            DelayAddr: CfgReadData = CfgDataWidth'(StartDelay);
            DropAddr:  CfgReadData = CfgDataWidth'(dropCount);
            default:   CfgReadData = '0;
        endcase
    end

endmodule

// ==== src/ResultFifo.sv ====
`timescale 1ns/1ps

module ResultFifo
    import AdcPkg::*;
(
    input  logic                     Clk,
    input  logic                     reset_n,
    input  logic                     ResultValid,
    input  logic [ResultWidth-1:0]   Result,
    input  logic                     ResultOtr,
    input  logic                     FifoRead,
    output logic [FifoWordWidth-1:0] FifoData,
    output logic                     FifoEmpty,
    output logic                     Dropped
);

    logic [FifoWordWidth-1:0]  mem [FifoDepth];
    logic [PtrWidth-1:0]       wrPtr;
    logic [PtrWidth-1:0]       rdPtr;
    logic [FifoCountWidth-1:0] count;
    logic                      full;
    logic                      doWrite;
    logic                      doRead;

    assign full      = (count == FifoCountWidth'(FifoDepth));
    assign FifoEmpty = (count == '0);
    // Reads while empty do nothing
    assign doRead    = FifoRead && !FifoEmpty;
    // Full means the new word is thrown away
    assign doWrite   = ResultValid && !full;

    // Head word always on the output
    assign FifoData  = mem[rdPtr];

    ////////////////////////////////////////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (doWrite) begin
            mem[wrPtr] <= {ResultOtr, Result};
        end
    end

    // Depth is a power of two so pointers wrap by themselves
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // One pulse per lost result
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            Dropped <= 1'b0;
        end else begin
            Dropped <= ResultValid && full;
        end
    end

endmodule

// ==== src/AdcDaq.sv ====
`timescale 1ns/1ps

module AdcDaq
    import AdcPkg::*;
(
    input  logic                     Clk,
    input  logic                     reset_n,
    input  logic                     Hold,
    input  logic                     CfgWrite,
    input  logic [AddrWidth-1:0]     CfgAddr,
    input  logic [CfgDataWidth-1:0]  CfgWriteData,
    output logic [CfgDataWidth-1:0]  CfgReadData,
    input  logic [AdcWidth-1:0]      AdcData,
    input  logic                     AdcOtr,
    output logic                     AdcClk,
    input  logic                     FifoRead,
    output logic [FifoWordWidth-1:0] FifoData,
    output logic                     FifoEmpty
);

    // Config to controller
    logic                   acqEnable;
    logic [DelayWidth-1:0]  startDelay;
    // Controller and sampler
    logic                   samplerRun;
    logic                   sampleValid;
    logic [AdcWidth-1:0]    sample;
    logic                   sampleOtr;
    // Controller to queue, and the drop count back
    logic                   resultValid;
    logic [ResultWidth-1:0] result;
    logic                   resultOtr;
    logic                   dropped;

    AcqConfig cfg0 (
        .Clk          (Clk),
        .reset_n      (reset_n),
        .CfgWrite     (CfgWrite),
        .CfgAddr      (CfgAddr),
        .CfgWriteData (CfgWriteData),
        .CfgReadData  (CfgReadData),
        .Dropped      (dropped),
        .AcqEnable    (acqEnable),
        .StartDelay   (startDelay)
    );

    AdcControl control0 (
        .Clk         (Clk),
        .reset_n     (reset_n),
        .Hold        (Hold),
        .AcqEnable   (acqEnable),
        .StartDelay  (startDelay),
        .SampleValid (sampleValid),
        .Sample      (sample),
        .SampleOtr   (sampleOtr),
        .SamplerRun  (samplerRun),
        .ResultValid (resultValid),
        .Result      (result),
        .ResultOtr   (resultOtr)
    );

    AdcSampler sampler0 (
        .Clk         (Clk),
        .reset_n     (reset_n),
        .SamplerRun  (samplerRun),
        .AdcData     (AdcData),
        .AdcOtr      (AdcOtr),
        .AdcClk      (AdcClk),
        .SampleValid (sampleValid),
        .Sample      (sample),
        .SampleOtr   (sampleOtr)
    );

    ResultFifo fifo0 (
        .Clk         (Clk),
        .reset_n     (reset_n),
        .ResultValid (resultValid),
        .Result      (result),
        .ResultOtr   (resultOtr),
        .FifoRead    (FifoRead),
        .FifoData    (FifoData),
        .FifoEmpty   (FifoEmpty),
        .Dropped     (dropped)
    );

endmodule

// ==== testbench/ClockGen.sv ====
`timescale 1ns/1ps

module ClockGen (
    output logic Clk,
    output logic reset_n
);

    // 4 ns period, starts low
    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    // Held low over the first 3 rising edges
    initial begin
        reset_n = 1'b0;
        repeat (3) @(posedge Clk);
        #1 reset_n = 1'b1;
    end

endmodule

// ==== testbench/Ad9220Model.sv ====
`timescale 1ns/1ps

module Ad9220Model
    import AdcPkg::*;
(
    input  logic                reset_n,
    input  logic                AdcClk,
    input  logic [AdcWidth-1:0] Level,
    input  logic                OtrIn,
    output logic [AdcWidth-1:0] AdcData,
    output logic                AdcOtr
);

    // Conversion pipeline, one stage per ADC clock
    logic [AdcWidth-1:0] data1;
    logic [AdcWidth-1:0] data2;
    logic [AdcWidth-1:0] data3;
    logic                otr1;
    logic                otr2;
    logic                otr3;

    always_ff @(posedge AdcClk or negedge reset_n) begin
        if (!reset_n) begin
            data1   <= '0;
            data2   <= '0;
            data3   <= '0;
            otr1    <= 1'b0;
            otr2    <= 1'b0;
            otr3    <= 1'b0;
            AdcData <= '0;
            AdcOtr  <= 1'b0;
        end else begin
            data1   <= Level;
            otr1    <= OtrIn;
            data2   <= data1;
            otr2    <= otr1;
            data3   <= data2;
            otr3    <= otr2;
            // Bus shows what was sampled three edges back
            AdcData <= data3;
            AdcOtr  <= otr3;
        end
    end

endmodule

// ==== testbench/AdcDaq_sva.sv ====
`timescale 1ns/1ps

module AdcDaqSva
    import AdcPkg::*;
(
    input logic    Clk,
    input logic    reset_n,
    input AcqState state,
    input logic    SamplerRun,
    input logic    SampleValid,
    input logic    ResultValid
);

    // Emit is a single state, so the strobe is a single cycle
    resultPulse: assert property (@(posedge Clk) disable iff (!reset_n)
        ResultValid |=> !ResultValid)
        else $error("ResultValid stayed high for more than one cycle");

    // ADC clock parked while waiting for Hold
    idleParked: assert property (@(posedge Clk) disable iff (!reset_n)
        (state == Idle) |-> !SamplerRun)
        else $error("SamplerRun high while the controller is Idle");

    // Conversions only arrive inside a burst
    sampleInBurst: assert property (@(posedge Clk) disable iff (!reset_n)
        SampleValid |-> SamplerRun)
        else $error("SampleValid pulsed while SamplerRun is low");

endmodule

bind AdcControl AdcDaqSva sva0 (
    .Clk         (Clk),
    .reset_n     (reset_n),
    .state       (state),
    .SamplerRun  (SamplerRun),
    .SampleValid (SampleValid),
    .ResultValid (ResultValid)
);

// ==== testbench/AdcDaqTb.sv ====
`timescale 1ns/1ps

module AdcDaqTb
    import AdcPkg::*;
();

    logic                     Clk;
    logic                     reset_n;
    logic                     Hold;
    logic                     CfgWrite;
    logic [AddrWidth-1:0]     CfgAddr;
    logic [CfgDataWidth-1:0]  CfgWriteData;
    logic [CfgDataWidth-1:0]  CfgReadData;
    logic [AdcWidth-1:0]      AdcData;
    logic                     AdcOtr;
    logic                     AdcClk;
    logic                     FifoRead;
    logic [FifoWordWidth-1:0] FifoData;
    logic                     FifoEmpty;

    // ADC model inputs held constant through a burst
    logic [AdcWidth-1:0]      level;
    logic                     overRange;

    // Expected FIFO words in arrival order
    logic [FifoWordWidth-1:0] expectQ [$];
    logic [FifoWordWidth-1:0] headWord;
    logic [31:0]              rngState;
    string                    testName;
    int                       errorCount;
    int                       checkCount;
    int                       highCycles;
    logic                     timedOut;

    ClockGen clkGen0 (
        .Clk     (Clk),
        .reset_n (reset_n)
    );

    Ad9220Model adc0 (
        .reset_n (reset_n),
        .AdcClk  (AdcClk),
        .Level   (level),
        .OtrIn   (overRange),
        .AdcData (AdcData),
        .AdcOtr  (AdcOtr)
    );

    AdcDaq dut0 (
        .Clk          (Clk),
        .reset_n      (reset_n),
        .Hold         (Hold),
        .CfgWrite     (CfgWrite),
        .CfgAddr      (CfgAddr),
        .CfgWriteData (CfgWriteData),
        .CfgReadData  (CfgReadData),
        .AdcData      (AdcData),
        .AdcOtr       (AdcOtr),
        .AdcClk       (AdcClk),
        .FifoRead     (FifoRead),
        .FifoData     (FifoData),
        .FifoEmpty    (FifoEmpty)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and random levels
    ////////////////////////////////////////////////////////////////////////////

    // 32 equal samples sum to lvl*32 and half of that is lvl*16
    function automatic logic [FifoWordWidth-1:0] expectedWord(
        input logic [AdcWidth-1:0] lvl,
        input logic                otr
    );
        return {otr, lvl, 4'b0000};
    endfunction

    // xorshift32
    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Bus tasks start and end 1 ns after a rising edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic writeReg(
        input logic [AddrWidth-1:0]    addr,
        input logic [CfgDataWidth-1:0] data
    );
        CfgWrite     = 1'b1;
        CfgAddr      = addr;
        CfgWriteData = data;
        @(posedge Clk);
        #1;
        CfgWrite = 1'b0;
    endtask

    // Combinational readback sampled mid cycle
    task automatic checkReg(
        input logic [AddrWidth-1:0]    addr,
        input logic [CfgDataWidth-1:0] expected
    );
        CfgAddr = addr;
        @(negedge Clk);
        checkCount++;
        if (CfgReadData !== expected) begin
            errorCount++;
            $display("[ERROR] %s: register %0d expected %h, actual %h",
                     testName, addr, expected, CfgReadData);
        end
        @(posedge Clk);
        #1;
    endtask

    task automatic checkEmpty();
        checkCount++;
        if (FifoEmpty !== 1'b1) begin
            errorCount++;
            $display("[ERROR] %s: FifoEmpty expected 1, actual %b", testName, FifoEmpty);
        end
    endtask

    task automatic pulseHold();
        Hold = 1'b1;
        repeat (3) @(posedge Clk);
        #1;
        Hold = 1'b0;
    endtask

    task automatic waitForWord();
        int cycles;
        cycles = 0;
        while (FifoEmpty && cycles < 2000) begin
            @(posedge Clk);
            #1;
            cycles++;
        end
        if (FifoEmpty) begin
            errorCount++;
            $display("%s: no result reached the FIFO within 2000 cycles", testName);
            timedOut = 1'b1;
        end
    endtask

    // Nothing may arrive while acquisition is blocked
    task automatic expectNoWord();
        int cycles;
        cycles = 0;
        while (FifoEmpty && cycles < 2000) begin
            @(posedge Clk);
            #1;
            cycles++;
        end
        checkEmpty();
    endtask

    // Full FIFO hides new results so watch the controller strobe
    task automatic waitForResultPulse();
        int cycles;
        cycles = 0;
        @(negedge Clk);
        while (!dut0.resultValid && cycles < 2000) begin
            @(negedge Clk);
            cycles++;
        end
        if (!dut0.resultValid) begin
            errorCount++;
            $display("%s: controller gave no result within 2000 cycles", testName);
            timedOut = 1'b1;
        end
        @(posedge Clk);
        #1;
    endtask

    task automatic readWord();
        FifoRead = 1'b1;
        @(posedge Clk);
        #1;
        FifoRead = 1'b0;
    endtask

    // New random level followed by one Hold
    task automatic launchBurst(input logic otr, input logic keep);
        rngState  = nextRandom(rngState);
        level     = rngState[AdcWidth-1:0];
        overRange = otr;
        if (keep) begin
            expectQ.push_back(expectedWord(level, otr));
        end
        pulseHold();
    endtask

    task automatic runBurst(input logic otr);
        launchBurst(otr, 1'b1);
        waitForWord();
        readWord();
        // One Hold gives exactly one word
        checkEmpty();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare each word as it is read
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge Clk) begin
        if (FifoRead && !FifoEmpty) begin
            if (expectQ.size() == 0) begin
                errorCount++;
                $display("%s: FIFO handed out a word that no burst should have made",
                         testName);
            end else begin
                headWord = expectQ.pop_front();
                checkCount++;
                if (FifoData !== headWord) begin
                    errorCount++;
                    $display("[ERROR] %s: FIFO word expected %h, actual %h",
                             testName, headWord, FifoData);
                end
            end
        end
    end

    // ADC clock high phase lasts half of AdcClkDiv system clocks
    always @(negedge Clk) begin
        if (AdcClk === 1'b1) begin
            highCycles++;
        end else if (highCycles != 0) begin
            checkCount++;
            if (highCycles != AdcClkDiv / 2) begin
                errorCount++;
                $display("[ERROR] %s: AdcClk high cycles expected %0d, actual %0d",
                         testName, AdcClkDiv / 2, highCycles);
            end
            highCycles = 0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    task automatic runTests();
        int cycles;
        int i;
        cycles = 0;
        while (!reset_n && cycles < 20) begin
            @(posedge Clk);
            cycles++;
        end
        if (!reset_n) begin
            errorCount++;
            $display("reset_n never went high");
            timedOut = 1'b1;
        end
        @(posedge Clk);
        #1;

        testName = "registers";
        checkReg(DropAddr, 8'h00);
        // Only the low 4 bits of the delay are kept
        writeReg(DelayAddr, 8'hF9);
        checkReg(DelayAddr, 8'h09);
        writeReg(CtrlAddr, 8'h01);
        checkReg(CtrlAddr, 8'h01);
        writeReg(DelayAddr, 8'h03);
        checkReg(DelayAddr, 8'h03);

        testName = "accumulate";
        for (i = 0; i < 8; i++) begin
            runBurst(1'b0);
        end

        // Sticky flag must not leak into the next burst
        testName = "overrange";
        runBurst(1'b1);
        runBurst(1'b0);

        testName = "enable";
        writeReg(CtrlAddr, 8'h00);
        checkReg(CtrlAddr, 8'h00);
        pulseHold();
        expectNoWord();
        // Level already high when enabled is no edge
        Hold = 1'b1;
        repeat (8) @(posedge Clk);
        #1;
        writeReg(CtrlAddr, 8'h01);
        expectNoWord();
        Hold = 1'b0;
        repeat (4) @(posedge Clk);
        #1;
        runBurst(1'b0);

        // Last two results hit a full FIFO
        testName = "backpressure";
        for (i = 0; i < 10; i++) begin
            launchBurst(1'b0, i < FifoDepth);
            waitForResultPulse();
        end
        for (i = 0; i < FifoDepth; i++) begin
            waitForWord();
            readWord();
        end
        checkEmpty();
        checkReg(DropAddr, 8'h02);
        writeReg(DropAddr, 8'h00);
        checkReg(DropAddr, 8'h00);

        testName = "delay";
        writeReg(DelayAddr, 8'h00);
        runBurst(1'b0);
        writeReg(DelayAddr, 8'h0F);
        checkReg(DelayAddr, 8'h0F);
        runBurst(1'b1);
    endtask

    initial begin
        Hold         = 1'b0;
        CfgWrite     = 1'b0;
        CfgAddr      = '0;
        CfgWriteData = '0;
        FifoRead     = 1'b0;
        level        = '0;
        overRange    = 1'b0;
        rngState     = 32'd7109;
        errorCount   = 0;
        checkCount   = 0;
        highCycles   = 0;
        timedOut     = 1'b0;
        testName     = "reset";

        // A timeout cuts the sequence short
        fork
            runTests();
            wait (timedOut);
        join_any

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
src/AdcPkg.sv
src/AdcSampler.sv
src/AdcControl.sv
src/AcqConfig.sv
src/ResultFifo.sv
src/AdcDaq.sv
testbench/ClockGen.sv
testbench/Ad9220Model.sv
testbench/AdcDaq_sva.sv
testbench/AdcDaqTb.sv

// ==== Makefile ====
TOP = AdcDaqTb
OBJ = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ) -f sim.f
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ)
